/* rtl/uart_pkg.sv */
package uart_pkg;

    // Payload bits carried by one frame
    localparam int UART_DATA_BITS = 8;

    // Parity sense, 1 means the parity bit makes the count of ones even
    localparam bit UART_PARITY_EVEN = 1'b1;

    // Start bit, data bits, parity bit and one stop bit
    localparam int UART_FRAME_BITS = 1 + UART_DATA_BITS + 1 + 1;

endpackage : uart_pkg

/* rtl/steer_pkg.sv */
package steer_pkg;

    // Half-bridge channels driven by one module
    localparam int NUM_CH = 3;

    // Width of the carrier phase counter and of the phase step
    localparam int PHASE_W = 8;

    // Width of the burst length in carrier periods
    localparam int CYCLES_W = 8;

    // Command opcode in the upper nibble of the first byte
    typedef enum logic [3:0] {
        OP_SET_STEP   = 4'd1,
        OP_SET_CYCLES = 4'd2
    } opcode_t;

    // Command decoder states
    typedef enum logic [1:0] {
        WAIT_HI,
        WAIT_LO,
        RX_ERROR
    } dec_state_t;

endpackage : steer_pkg

/* rtl/carrier_if.sv */
`timescale 1ns/1ps

interface carrier_if import steer_pkg::*; ();

    logic [PHASE_W-1:0] phase;
    logic               active;
    // High on the first clock of each period of a running burst
    logic               period_start;
    // High during the final period of a burst
    logic               last_period;

    modport timer (output phase, output active, output period_start, output last_period);

    modport driver (input phase, input active, input period_start, input last_period);

endinterface : carrier_if

/* rtl/uart_rx.sv */
`timescale 1ns/1ps

module uart_rx import uart_pkg::*; #(
    parameter int CLKS_PER_BIT = 8
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      rx,
    output logic [UART_DATA_BITS-1:0] byte_data,
    output logic                      byte_valid,
    output logic                      parity_error
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam int IDX_W = $clog2(UART_FRAME_BITS);

    typedef enum logic {
        RX_IDLE,
        RX_FRAME
    } rx_state_t;

    rx_state_t                 state;
    logic                      rx_meta;
    logic                      rx_sync;
    logic [CNT_W-1:0]          clk_cnt;
    logic [IDX_W-1:0]          bit_idx;
    logic [UART_DATA_BITS-1:0] shift_reg;
    logic                      parity_bit;
    logic                      parity_exp;

    // Two-flop synchronizer, line idles high
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    // Parity bit the sender should have put on the line
    assign parity_exp = (^shift_reg) ^ ~UART_PARITY_EVEN;

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= RX_IDLE;
            clk_cnt      <= '0;
            bit_idx      <= '0;
            byte_valid   <= 1'b0;
            parity_error <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    if (!rx_sync) begin
                        // Aim at the middle of the start bit
                        clk_cnt <= CNT_W'(CLKS_PER_BIT / 2 - 1);
                        bit_idx <= '0;
                        state   <= RX_FRAME;
                    end
                end
                RX_FRAME: begin
                    if (clk_cnt != '0) begin
                        clk_cnt <= clk_cnt - 1'b1;
                    end else begin
                        clk_cnt <= CNT_W'(CLKS_PER_BIT - 1);
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == '0) begin
                            // Line back high already, so it was a glitch
                            if (rx_sync) begin
                                state <= RX_IDLE;
                            end
                        end else if (int'(bit_idx) <= UART_DATA_BITS) begin
                            // LSB first
                            shift_reg <= {rx_sync, shift_reg[UART_DATA_BITS-1:1]};
                        end else if (int'(bit_idx) == UART_DATA_BITS + 1) begin
                            parity_bit <= rx_sync;
                        end else if (int'(bit_idx) == UART_FRAME_BITS - 1) begin
                            // Mid stop bit, hand the byte over
                            byte_data    <= shift_reg;
                            byte_valid   <= 1'b1;
                            parity_error <= (parity_bit != parity_exp) || !rx_sync;
                            state        <= RX_IDLE;
                        end
                    end
                end
                default: begin
                    state <= RX_IDLE;
                end
            endcase
        end
    end

    // A frame is far longer than one clock
    a_single_strobe: assert property (
        @(posedge clk) disable iff (rst) byte_valid |=> !byte_valid
    );

endmodule : uart_rx

/* rtl/cmd_decoder.sv */
`timescale 1ns/1ps

module cmd_decoder import steer_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic [7:0]          byte_data,
    input  logic                byte_valid,
    input  logic                parity_error,
    output logic [PHASE_W-1:0]  phase_step,
    output logic [CYCLES_W-1:0] burst_cycles,
    output logic                rx_error
);

    dec_state_t  state;
    opcode_t     op_q;
    logic [3:0]  nib_q;
    logic [11:0] step_word;
    logic        op_ok;

    // Only two opcodes are defined
    assign op_ok = (byte_data[7:4] == OP_SET_STEP) || (byte_data[7:4] == OP_SET_CYCLES);

    // Low nibble of the first byte joined with the second byte
    assign step_word = {nib_q, byte_data};

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= WAIT_HI;
            op_q         <= OP_SET_STEP;
            nib_q        <= '0;
            phase_step   <= '0;
            burst_cycles <= '0;
        end else begin
            case (state)
                WAIT_HI: begin
                    if (byte_valid) begin
                        if (parity_error || !op_ok) begin
                            state <= RX_ERROR;
                        end else begin
                            op_q  <= opcode_t'(byte_data[7:4]);
                            nib_q <= byte_data[3:0];
                            state <= WAIT_LO;
                        end
                    end
                end
                WAIT_LO: begin
                    if (byte_valid) begin
                        if (parity_error) begin
                            state <= RX_ERROR;
                        end else begin
                            state <= WAIT_HI;
                            case (op_q)
                                OP_SET_STEP: begin
                                    phase_step <= step_word[PHASE_W-1:0];
                                end
                                OP_SET_CYCLES: begin
                                    burst_cycles <= byte_data[CYCLES_W-1:0];
                                end
                                default: begin
                                    state <= RX_ERROR;
                                end
                            endcase
                        end
                    end
                end
                // Locked until reset, settings stay as they were
                RX_ERROR: begin
                    state <= RX_ERROR;
                end
                default: begin
                    state <= RX_ERROR;
                end
            endcase
        end
    end

    assign rx_error = (state == RX_ERROR);

    // Sticky error
    a_error_sticky: assert property (
        @(posedge clk) disable iff (rst) rx_error |=> rx_error
    );

endmodule : cmd_decoder

/* rtl/burst_timer.sv */
`timescale 1ns/1ps

module burst_timer import steer_pkg::*; #(
    parameter int PERIOD = 16
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                shoot,
    input  logic [CYCLES_W-1:0] burst_cycles,
    carrier_if.timer            car
);

    localparam logic [PHASE_W-1:0] PH_LAST = PHASE_W'(PERIOD - 1);

    logic                shoot_q;
    logic                shoot_rise;
    logic [CYCLES_W-1:0] periods_left;

    assign shoot_rise = shoot && !shoot_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            shoot_q      <= 1'b0;
            car.active   <= 1'b0;
            car.phase    <= '0;
            periods_left <= '0;
        end else begin
            shoot_q <= shoot;
            if (!car.active) begin
                car.phase <= '0;
                // Zero length means no burst at all
                if (shoot_rise && burst_cycles != '0) begin
                    car.active   <= 1'b1;
                    periods_left <= burst_cycles;
                end
            end else if (car.phase == PH_LAST) begin
                car.phase    <= '0;
                periods_left <= periods_left - 1'b1;
                if (periods_left == CYCLES_W'(1)) begin
                    car.active <= 1'b0;
                end
            end else begin
                car.phase <= car.phase + 1'b1;
            end
        end
    end

    assign car.period_start = car.active && (car.phase == '0);
    assign car.last_period  = car.active && (periods_left == CYCLES_W'(1));

    // Phase wraps at the carrier period
    a_phase_range: assert property (
        @(posedge clk) disable iff (rst) car.active |-> int'(car.phase) < PERIOD
    );

endmodule : burst_timer

/* rtl/gate_driver.sv */
`timescale 1ns/1ps

module gate_driver import steer_pkg::*; #(
    parameter int PERIOD = 16
) (
    input  logic               clk,
    input  logic               rst,
    input  logic [PHASE_W-1:0] phase_step,
    carrier_if.driver          car,
    output logic [NUM_CH-1:0]  gate_hi,
    output logic [NUM_CH-1:0]  gate_lo
);

    localparam int HALF = PERIOD / 2;

    logic [PHASE_W-1:0] step_q;
    logic [PHASE_W-1:0] step_cur;
    logic [NUM_CH-1:0]  hi_next;

    // A new step only takes effect on a period boundary
    assign step_cur = car.period_start ? phase_step : step_q;

    always_ff @(posedge clk) begin
        if (car.period_start) begin
            step_q <= phase_step;
        end
    end

    for (genvar k = 0; k < NUM_CH; k++) begin : g_ch
        int offset;
        int shifted;

        // Channel k lags by k steps, taken modulo the period
        assign offset  = (k * int'(step_cur)) % PERIOD;
        assign shifted = (int'(car.phase) >= offset) ? int'(car.phase) - offset
                                                     : int'(car.phase) + PERIOD - offset;
        assign hi_next[k] = (shifted < HALF);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            gate_hi <= '0;
            gate_lo <= '0;
        end else if (car.active) begin
            gate_hi <= hi_next;
            gate_lo <= ~hi_next;
        end else begin
            gate_hi <= '0;
            gate_lo <= '0;
        end
    end

    // No shoot-through on any half bridge
    a_no_overlap: assert property (
        @(posedge clk) disable iff (rst) (gate_hi & gate_lo) == '0
    );

    // All gates released two clocks after the last phase of a burst
    a_burst_end: assert property (
        @(posedge clk) disable iff (rst)
        car.last_period && int'(car.phase) == PERIOD - 1 |=> ##1 (gate_hi == '0 && gate_lo == '0)
    );

endmodule : gate_driver

/* rtl/transducer_top.sv */
`timescale 1ns/1ps

module transducer_top import steer_pkg::*; #(
    parameter int CLKS_PER_BIT = 8,
    parameter int PERIOD       = 16
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              rx,
    input  logic              shoot,
    output logic [NUM_CH-1:0] gate_hi,
    output logic [NUM_CH-1:0] gate_lo,
    output logic              rx_error
);

    logic [7:0]          byte_data;
    logic                byte_valid;
    logic                parity_error;
    logic [PHASE_W-1:0]  phase_step;
    logic [CYCLES_W-1:0] burst_cycles;

    // Carrier timebase shared by timer and driver
    carrier_if car ();

    uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_rx (
        .clk          (clk),
        .rst          (rst),
        .rx           (rx),
        .byte_data    (byte_data),
        .byte_valid   (byte_valid),
        .parity_error (parity_error)
    );

    cmd_decoder u_cmd_decoder (
        .clk          (clk),
        .rst          (rst),
        .byte_data    (byte_data),
        .byte_valid   (byte_valid),
        .parity_error (parity_error),
        .phase_step   (phase_step),
        .burst_cycles (burst_cycles),
        .rx_error     (rx_error)
    );

    burst_timer #(.PERIOD(PERIOD)) u_burst_timer (
        .clk          (clk),
        .rst          (rst),
        .shoot        (shoot),
        .burst_cycles (burst_cycles),
        .car          (car.timer)
    );

    gate_driver #(.PERIOD(PERIOD)) u_gate_driver (
        .clk        (clk),
        .rst        (rst),
        .phase_step (phase_step),
        .car        (car.driver),
        .gate_hi    (gate_hi),
        .gate_lo    (gate_lo)
    );

endmodule : transducer_top

/* tests/tb_uart_tasks.svh */
`ifndef TB_UART_TASKS_SVH
`define TB_UART_TASKS_SVH

// Hold rx for one bit period, starting on a falling edge
task automatic drive_bit(input logic level);
    rx = level;
    repeat (CLKS_PER_BIT) @(negedge clk);
endtask

// One 8E1 frame, LSB first
task automatic send_byte(input logic [7:0] data, input bit bad_parity);
    logic parity;
    // Even parity, flipped on request
    parity = (^data) ^ bad_parity;
    drive_bit(1'b0);
    for (int i = 0; i < 8; i++) begin
        drive_bit(data[i]);
    end
    drive_bit(parity);
    drive_bit(1'b1);
    // Extra idle bit lets the decoder settle
    drive_bit(1'b1);
endtask

`endif

/* tests/tb_transducer.sv */
`timescale 1ns/1ps

module tb_transducer import steer_pkg::*; ();

    localparam int CLKS_PER_BIT   = 8;
    localparam int PERIOD         = 16;
    localparam int NUM_ROWS       = 12;
    localparam int START_WINDOW   = 4 * PERIOD;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * (2 * 11 * CLKS_PER_BIT + 255 * PERIOD) + 2000;

    // Shoot modes of a table row
    localparam logic [1:0] S_PULSE  = 2'd1;
    localparam logic [1:0] S_HOLD   = 2'd2;
    localparam logic [1:0] S_REPEAT = 2'd3;

    typedef struct packed {
        logic       pre_reset;
        logic [7:0] byte_hi;
        logic [7:0] byte_lo;
        logic       bad_parity;
        logic [1:0] shoot_mode;
        logic [7:0] exp_step;
        logic [7:0] exp_cycles;
        logic       exp_error;
    } row_t;

    logic              clk = 1'b0;
    logic              rst;
    logic              rx;
    logic              shoot;
    logic [NUM_CH-1:0] gate_hi;
    logic [NUM_CH-1:0] gate_lo;
    logic              rx_error;
    row_t              rows [NUM_ROWS];
    int                seed = 93;
    int                cycle_cnt = 0;

    transducer_top #(.CLKS_PER_BIT(CLKS_PER_BIT), .PERIOD(PERIOD)) UUT (
        .clk      (clk),
        .rst      (rst),
        .rx       (rx),
        .shoot    (shoot),
        .gate_hi  (gate_hi),
        .gate_lo  (gate_lo),
        .rx_error (rx_error)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
            $display("Simulation finished: FAIL");
            $fatal(1, "Timeout");
        end
    end

    `include "tb_uart_tasks.svh"

    task automatic report_mismatch(input string name, input int expected, input int actual);
        $display("CHECK FAILED at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
        $display("Simulation finished: FAIL");
        $fatal(1, "Mismatch on %s", name);
    endtask

    // Channel k lags channel 0 by k steps, modulo the carrier period
    function automatic bit expected_hi(input int n, input int k, input int step);
        int shifted;
        shifted = ((n % PERIOD) - (k * step) % PERIOD + PERIOD) % PERIOD;
        return shifted < PERIOD / 2;
    endfunction

    task automatic apply_reset();
        rst   = 1'b1;
        shoot = 1'b0;
        repeat (3) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        assert (gate_hi == '0) else report_mismatch("gate_hi", 0, gate_hi);
        assert (gate_lo == '0) else report_mismatch("gate_lo", 0, gate_lo);
        assert (rx_error == 1'b0) else report_mismatch("rx_error", 0, rx_error);
    endtask

    // Burst starts on the first clock with any gate high
    task automatic check_burst(input int step, input int cycles, input bit repeat_shoot);
        int wait_cnt;
        bit burst_seen;
        bit exp_hi;
        bit exp_lo;
        wait_cnt = 0;
        while ((gate_hi | gate_lo) == '0 && wait_cnt < START_WINDOW) begin
            @(negedge clk);
            wait_cnt++;
        end
        burst_seen = ((gate_hi | gate_lo) != '0);
        assert (burst_seen == (cycles != 0))
            else report_mismatch("burst_seen", int'(cycles != 0), int'(burst_seen));
        if (burst_seen) begin
            // One extra period after the burst must stay quiet
            for (int n = 0; n < (cycles + 1) * PERIOD; n++) begin
                for (int k = 0; k < NUM_CH; k++) begin
                    exp_hi = (n < cycles * PERIOD) && expected_hi(n, k, step);
                    exp_lo = (n < cycles * PERIOD) && !exp_hi;
                    assert (gate_hi[k] == exp_hi)
                        else report_mismatch($sformatf("gate_hi[%0d]", k), exp_hi, gate_hi[k]);
                    assert (gate_lo[k] == exp_lo)
                        else report_mismatch($sformatf("gate_lo[%0d]", k), exp_lo, gate_lo[k]);
                end
                if (repeat_shoot) begin
                    shoot = (n == PERIOD + 2);
                end
                @(negedge clk);
            end
        end
    endtask

    task automatic load_table();
        logic [31:0] rnd;
        rnd = $random(seed);
        rows[0]  = '{1'b0, 8'h10, 8'h00, 1'b0, S_PULSE, 8'd0, 8'd0, 1'b0};
        rows[1]  = '{1'b0, 8'h20, 8'h03, 1'b0, S_PULSE, 8'd0, 8'd3, 1'b0};
        rows[2]  = '{1'b0, 8'h10, 8'h04, 1'b0, S_PULSE, 8'd4, 8'd3, 1'b0};
        // Upper nibble of the step word is dropped
        rows[3]  = '{1'b0, 8'h1f, 8'h05, 1'b0, S_PULSE, 8'd5, 8'd3, 1'b0};
        rows[4]  = '{1'b0, {4'h1, rnd[11:8]}, rnd[7:0], 1'b0, S_PULSE, rnd[7:0], 8'd3, 1'b0};
        rows[5]  = '{1'b0, 8'h20, 8'h02, 1'b0, S_HOLD, rnd[7:0], 8'd2, 1'b0};
        rows[6]  = '{1'b0, 8'h10, 8'h07, 1'b0, S_REPEAT, 8'd7, 8'd2, 1'b0};
        rows[7]  = '{1'b0, 8'h20, 8'h09, 1'b1, S_PULSE, 8'd7, 8'd2, 1'b1};
        rows[8]  = '{1'b0, 8'h20, 8'h05, 1'b0, S_PULSE, 8'd7, 8'd2, 1'b1};
        rows[9]  = '{1'b1, 8'h20, 8'h02, 1'b0, S_PULSE, 8'd0, 8'd2, 1'b0};
        // Opcode 3 is undefined
        rows[10] = '{1'b0, 8'h35, 8'h01, 1'b0, S_PULSE, 8'd0, 8'd2, 1'b1};
        rows[11] = '{1'b0, 8'h10, 8'h03, 1'b0, S_PULSE, 8'd0, 8'd2, 1'b1};
    endtask

    initial begin
        rst   = 1'b1;
        rx    = 1'b1;
        shoot = 1'b0;
        load_table();
        apply_reset();
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (rows[r].pre_reset) begin
                apply_reset();
            end
            send_byte(rows[r].byte_hi, rows[r].bad_parity);
            send_byte(rows[r].byte_lo, 1'b0);
            assert (rx_error == rows[r].exp_error)
                else report_mismatch("rx_error", rows[r].exp_error, rx_error);
            shoot = 1'b1;
            @(negedge clk);
            shoot = (rows[r].shoot_mode == S_HOLD);
            check_burst(rows[r].exp_step, rows[r].exp_cycles, rows[r].shoot_mode == S_REPEAT);
            shoot = 1'b0;
        end
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule : tb_transducer

/* flist.f */
+incdir+tests
rtl/uart_pkg.sv
rtl/steer_pkg.sv
rtl/carrier_if.sv
rtl/uart_rx.sv
rtl/cmd_decoder.sv
rtl/burst_timer.sv
rtl/gate_driver.sv
rtl/transducer_top.sv
tests/tb_transducer.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_transducer
FLIST     := flist.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(shell grep -v '^+' $(FLIST))
HDRS      := tests/tb_uart_tasks.svh

.PHONY: all run check clean

all: check

$(BIN): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)

check: run
	grep -q "^Simulation finished: PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
